/* Makefile */
# Verilator flow for the interrupt controller and its testbench

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= irq_ctrl_tb
RTL_TOP   ?= irq_ctrl_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+src
src/irq_cfg_pkg.sv
src/irq_core_pkg.sv
src/irq_reg_file.sv
src/irq_gateway.sv
src/irq_max_tree.sv
src/irq_claim_ctrl.sv
src/irq_ctrl_top.sv
test/irq_ctrl_sva.sv
test/irq_ctrl_tb.sv

/* src/irq_cfg_pkg.sv */
// Interrupt controller configuration types
// Holds the command opcode, the two views of the configuration word
// and the per-source configuration record

`include "irq_settings.svh"

package irq_cfg_pkg;

  // Opcode in the top bit of every configuration word
  typedef enum logic {
    OP_SRC    = 1'b0,
    OP_THRESH = 1'b1
  } cfg_op_e;

  // Total word width follows from the source-command layout
  localparam int cfg_word_w = 1 + `IRQ_ID_W + 1 + `IRQ_PRIO_W;
  localparam int thresh_pad_w = cfg_word_w - 1 - `IRQ_PRIO_W;

  // Source-command view, sets one source's enable and priority
  typedef struct packed {
    cfg_op_e                op;
    logic [`IRQ_ID_W-1:0]   src_id;
    logic                   enable;
    logic [`IRQ_PRIO_W-1:0] prio;
  } src_cmd_t;

  // Threshold-command view of the same word
  typedef struct packed {
    cfg_op_e                 op;
    logic [thresh_pad_w-1:0] pad;
    logic [`IRQ_PRIO_W-1:0]  threshold;
  } thresh_cmd_t;

  // The op field lines up in both views, so either view can read it
  typedef union packed {
    src_cmd_t    src;
    thresh_cmd_t thresh;
  } cfg_word_u;

  // Configuration held for one source
  typedef struct packed {
    logic                   enable;
    logic [`IRQ_PRIO_W-1:0] prio;
  } src_cfg_t;

endpackage

/* src/irq_claim_ctrl.sv */
// Claim and complete controller
// Compares the tree winner against the threshold, registers the
// interrupt line and runs the claim and complete handshakes

`timescale 1ns/10ps

`include "irq_settings.svh"

module irq_claim_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     max_valid_i,
  input  logic [`IRQ_PRIO_W-1:0]   max_prio_i,
  input  logic [`IRQ_ID_W-1:0]     max_idx_i,
  input  logic [`IRQ_PRIO_W-1:0]   threshold_i,
  input  logic                     claim_req_i,
  output logic                     claim_ack_o,
  output irq_core_pkg::claim_rsp_t claim_rsp_o,
  input  logic                     complete_req_i,
  input  logic [`IRQ_ID_W-1:0]     complete_id_i,
  output logic                     complete_ack_o,
  output logic [`IRQ_NUM_SRC-1:0]  claim_o,
  output logic [`IRQ_NUM_SRC-1:0]  complete_o,
  output logic                     irq_o
);

  localparam logic [`IRQ_NUM_SRC-1:0] one_hot_base = 1;

  logic above;
  logic claim_accept;
  logic complete_accept;

  // A zero priority can never be strictly above any threshold
  assign above = max_valid_i & (max_prio_i > threshold_i);

  assign claim_accept    = claim_req_i & ~claim_ack_o;
  assign complete_accept = complete_req_i & ~complete_ack_o;

  // Pulses are live only in the accept cycle so the gateways move
  // on the same edge that raises ack
  assign claim_o    = (claim_accept && above) ? (one_hot_base << max_idx_i) : '0;
  assign complete_o = complete_accept ? (one_hot_base << complete_id_i) : '0;

  ////////////////////////////////////////////////////////////
  // Registered outputs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_o          <= 1'b0;
      claim_ack_o    <= 1'b0;
      claim_rsp_o    <= '0;
      complete_ack_o <= 1'b0;
    end else begin
      irq_o <= above;
      // Each ack drops once its req is gone
      if (claim_accept) begin
        claim_ack_o       <= 1'b1;
        claim_rsp_o.valid <= above;
        claim_rsp_o.id    <= above ? max_idx_i : '0;
      end else if (!claim_req_i) begin
        claim_ack_o <= 1'b0;
      end
      if (complete_accept) begin
        complete_ack_o <= 1'b1;
      end else if (!complete_req_i) begin
        complete_ack_o <= 1'b0;
      end
    end
  end

endmodule

/* src/irq_core_pkg.sv */
// Interrupt controller datapath types
// Gateway request record and the claim response record

`include "irq_settings.svh"

package irq_core_pkg;

  ////////////////////////////////////////////////////////////
  // Gateway to max tree
  ////////////////////////////////////////////////////////////

  // Valid means the source is pending and enabled
  // The priority is carried along even when valid is low
  typedef struct packed {
    logic                   valid;
    logic [`IRQ_PRIO_W-1:0] prio;
  } src_req_t;

  ////////////////////////////////////////////////////////////
  // Claim port result
  ////////////////////////////////////////////////////////////

  // Valid is low when nothing was above the threshold at the claim,
  // and the id is then zero
  typedef struct packed {
    logic                 valid;
    logic [`IRQ_ID_W-1:0] id;
  } claim_rsp_t;

endpackage

/* src/irq_ctrl_top.sv */
// Interrupt controller top level for a single target
// Connects the register block, one gateway per source, the max tree
// and the claim and complete controller

`timescale 1ns/10ps

`include "irq_settings.svh"

module irq_ctrl_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [`IRQ_NUM_SRC-1:0]  irq_src_i,
  input  logic                     cfg_req_i,
  input  irq_cfg_pkg::cfg_word_u   cfg_word_i,
  output logic                     cfg_ack_o,
  input  logic                     claim_req_i,
  output logic                     claim_ack_o,
  output irq_core_pkg::claim_rsp_t claim_rsp_o,
  input  logic                     complete_req_i,
  input  logic [`IRQ_ID_W-1:0]     complete_id_i,
  output logic                     complete_ack_o,
  output logic                     irq_o
);

  irq_cfg_pkg::src_cfg_t  [`IRQ_NUM_SRC-1:0] src_cfg;
  irq_core_pkg::src_req_t [`IRQ_NUM_SRC-1:0] src_req;
  logic [`IRQ_PRIO_W-1:0]                    threshold;
  logic                                      max_valid;
  logic [`IRQ_PRIO_W-1:0]                    max_prio;
  logic [`IRQ_ID_W-1:0]                      max_idx;
  logic [`IRQ_NUM_SRC-1:0]                   claim;
  logic [`IRQ_NUM_SRC-1:0]                   complete;

  irq_reg_file i_reg_file (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_word_i  (cfg_word_i),
    .cfg_ack_o   (cfg_ack_o),
    .src_cfg_o   (src_cfg),
    .threshold_o (threshold)
  );

  // One gateway per source, all sharing the claim and complete vectors
  for (genvar i = 0; i < `IRQ_NUM_SRC; i++) begin : gen_gw
    irq_gateway i_gateway (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .src_i      (irq_src_i[i]),
      .cfg_i      (src_cfg[i]),
      .claim_i    (claim[i]),
      .complete_i (complete[i]),
      .req_o      (src_req[i])
    );
  end

  irq_max_tree #(
    .num_src (`IRQ_NUM_SRC),
    .width   (`IRQ_PRIO_W)
  ) i_max_tree (
    .req_i       (src_req),
    .max_valid_o (max_valid),
    .max_prio_o  (max_prio),
    .max_idx_o   (max_idx)
  );

  irq_claim_ctrl i_claim_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .max_valid_i    (max_valid),
    .max_prio_i     (max_prio),
    .max_idx_i      (max_idx),
    .threshold_i    (threshold),
    .claim_req_i    (claim_req_i),
    .claim_ack_o    (claim_ack_o),
    .claim_rsp_o    (claim_rsp_o),
    .complete_req_i (complete_req_i),
    .complete_id_i  (complete_id_i),
    .complete_ack_o (complete_ack_o),
    .claim_o        (claim),
    .complete_o     (complete),
    .irq_o          (irq_o)
  );

endmodule

/* src/irq_gateway.sv */
// Interrupt gateway for one level-sensitive source
// Latches the level as pending and blocks the source while it is
// in service, until the complete pulse releases it

`timescale 1ns/10ps

module irq_gateway (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   src_i,
  input  irq_cfg_pkg::src_cfg_t  cfg_i,
  input  logic                   claim_i,
  input  logic                   complete_i,
  output irq_core_pkg::src_req_t req_o
);

  // Request latched, waiting to be claimed
  logic pending;
  // Claimed by the core, not yet completed
  logic in_service;

  ////////////////////////////////////////////////////////////
  // Pending and in-service state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending    <= 1'b0;
      in_service <= 1'b0;
    end else begin
      // Complete only has an effect while the source is in service
      if (complete_i && in_service) begin
        in_service <= 1'b0;
      end
      if (claim_i && pending) begin
        // Claim hands the pending request over to service
        pending    <= 1'b0;
        in_service <= 1'b1;
      end else if (src_i && !pending && !in_service) begin
        // A high level is only sampled while the gateway is idle
        pending <= 1'b1;
      end
    end
  end

  // Disabled sources keep their pending bit but drop out of the tree
  assign req_o.valid = pending & cfg_i.enable;
  assign req_o.prio  = cfg_i.prio;

endmodule

/* src/irq_max_tree.sv */
// Priority max-finding tree
// Purely combinational binary tree over the gateway requests, which
// forwards the highest valid priority and its index to the root.
// Equal priorities resolve to the lower source index.

`timescale 1ns/10ps

`include "irq_settings.svh"

module irq_max_tree #(
  parameter int num_src = `IRQ_NUM_SRC,
  parameter int width   = `IRQ_PRIO_W
) (
  input  irq_core_pkg::src_req_t [num_src-1:0] req_i,
  output logic                                 max_valid_o,
  output logic [width-1:0]                     max_prio_o,
  output logic [`IRQ_ID_W-1:0]                 max_idx_o
);

  // Leaves are padded up to the next power of two
  localparam int num_levels = $clog2(num_src);
  localparam int num_nodes  = 2**(num_levels+1) - 1;
  localparam int id_w       = `IRQ_ID_W;

  // Node 0 is the root, the children of node n are 2n+1 and 2n+2
  logic [num_nodes-1:0]                 vld_tree;
  logic [num_nodes-1:0][id_w-1:0]       idx_tree;
  logic [num_nodes-1:0][width-1:0]      val_tree;

  for (genvar level = 0; level <= num_levels; level++) begin : gen_tree
    // First node of this level and of the level above it
    localparam int base0 = 2**level - 1;
    localparam int base1 = 2**(level+1) - 1;

    for (genvar offset = 0; offset < 2**level; offset++) begin : gen_level
      localparam int pa = base0 + offset;
      localparam int c0 = base1 + 2*offset;
      localparam int c1 = base1 + 2*offset + 1;

      if (level == num_levels) begin : gen_leaf
        if (offset < num_src) begin : gen_src
          assign vld_tree[pa] = req_i[offset].valid;
          assign idx_tree[pa] = id_w'(offset);
          assign val_tree[pa] = width'(req_i[offset].prio);
        end else begin : gen_pad
          // Padding leaves can never win
          assign vld_tree[pa] = 1'b0;
          assign idx_tree[pa] = '0;
          assign val_tree[pa] = '0;
        end
      end else begin : gen_node
        logic sel;
        // Take the upper child only if it alone is valid or it is
        // strictly greater, so the lower index wins on a tie
        assign sel = (~vld_tree[c0] & vld_tree[c1]) |
                     (vld_tree[c0] & vld_tree[c1] & (val_tree[c1] > val_tree[c0]));
        assign vld_tree[pa] = sel ? vld_tree[c1] : vld_tree[c0];
        assign idx_tree[pa] = sel ? idx_tree[c1] : idx_tree[c0];
        assign val_tree[pa] = sel ? val_tree[c1] : val_tree[c0];
      end
    end
  end

  // With nothing valid the root follows leaf 0, giving index 0
  assign max_valid_o = vld_tree[0];
  assign max_prio_o  = val_tree[0];
  assign max_idx_o   = idx_tree[0];

endmodule

/* src/irq_reg_file.sv */
// Configuration register block
// Takes one configuration word per four-phase handshake and keeps
// the per-source enables and priorities and the global threshold

`timescale 1ns/10ps

`include "irq_settings.svh"

module irq_reg_file (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         cfg_req_i,
  input  irq_cfg_pkg::cfg_word_u                       cfg_word_i,
  output logic                                         cfg_ack_o,
  output irq_cfg_pkg::src_cfg_t [`IRQ_NUM_SRC-1:0]     src_cfg_o,
  output logic [`IRQ_PRIO_W-1:0]                       threshold_o
);

  // A new request is only taken while ack is still low
  logic cfg_accept;

  assign cfg_accept = cfg_req_i & ~cfg_ack_o;

  ////////////////////////////////////////////////////////////
  // Handshake responder
  ////////////////////////////////////////////////////////////

  // Ack rises the cycle after acceptance and stays up while req is held
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_ack_o <= 1'b0;
    end else if (cfg_accept) begin
      cfg_ack_o <= 1'b1;
    end else if (!cfg_req_i) begin
      cfg_ack_o <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Register update
  ////////////////////////////////////////////////////////////

  // The op bit picks which view of the word is decoded
  // The new value takes effect on the same edge that raises ack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_cfg_o   <= '0;
      threshold_o <= '0;
    end else if (cfg_accept) begin
      if (cfg_word_i.src.op == irq_cfg_pkg::OP_SRC) begin
        src_cfg_o[cfg_word_i.src.src_id].enable <= cfg_word_i.src.enable;
        src_cfg_o[cfg_word_i.src.src_id].prio   <= cfg_word_i.src.prio;
      end else begin
        threshold_o <= cfg_word_i.thresh.threshold;
      end
    end
  end

endmodule

/* src/irq_settings.svh */
// Interrupt controller settings
// Sizing macros shared by the packages and the RTL blocks

`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Sizing
////////////////////////////////////////////////////////////

// Number of level-sensitive interrupt sources
`define IRQ_NUM_SRC 8

// Width of a source priority and of the global threshold
`define IRQ_PRIO_W 3

// Width of a source index, enough to name every source
`define IRQ_ID_W 3

`endif

/* test/irq_ctrl_sva.sv */
// Assertion checker for the interrupt controller
// Keeps a reference model of the configuration, the gateway state and
// the expected winner, and compares the DUT against it every cycle

`timescale 1ns/10ps

`include "irq_settings.svh"

module irq_ctrl_sva (
  input logic                                       clk_i,
  input logic                                       rst_i,
  input logic [`IRQ_NUM_SRC-1:0]                    irq_src_i,
  input logic                                       cfg_req_i,
  input irq_cfg_pkg::cfg_word_u                     cfg_word_i,
  input logic                                       cfg_ack_i,
  input logic                                       claim_req_i,
  input logic                                       claim_ack_i,
  input irq_core_pkg::claim_rsp_t                   claim_rsp_i,
  input logic                                       complete_req_i,
  input logic [`IRQ_ID_W-1:0]                       complete_id_i,
  input logic                                       complete_ack_i,
  input logic                                       irq_i,
  input irq_core_pkg::src_req_t [`IRQ_NUM_SRC-1:0]  src_req_i
);

  localparam int num_src = `IRQ_NUM_SRC;
  localparam int id_w    = `IRQ_ID_W;

  irq_cfg_pkg::src_cfg_t [num_src-1:0] cfg_m;
  logic [`IRQ_PRIO_W-1:0]              thr_m;
  logic [num_src-1:0]                  pend_m;
  logic [num_src-1:0]                  insvc_m;
  logic                                irq_m;
  irq_core_pkg::claim_rsp_t            rsp_m;
  logic                                win_valid;
  logic [`IRQ_PRIO_W-1:0]              win_prio;
  logic [id_w-1:0]                     win_id;
  logic                                above_m;
  logic [num_src-1:0]                  claim_hit;
  logic [num_src-1:0]                  done_hit;
  logic [num_src-1:0]                  valid_m;
  logic [num_src-1:0]                  valid_dut;
  // Number of assertion failures so far
  int                                  fail_count;

  ////////////////////////////////////////////////////////////
  // Expected winner
  ////////////////////////////////////////////////////////////

  // Scanning downwards with >= leaves the lowest index among equals
  always_comb begin
    win_valid = 1'b0;
    win_prio  = '0;
    win_id    = '0;
    for (int i = num_src - 1; i >= 0; i--) begin
      if (valid_m[i] && (!win_valid || cfg_m[i].prio >= win_prio)) begin
        win_valid = 1'b1;
        win_prio  = cfg_m[i].prio;
        win_id    = id_w'(i);
      end
    end
    above_m = win_valid && (win_prio > thr_m);
  end

  always_comb begin
    for (int i = 0; i < num_src; i++) begin
      valid_m[i]   = pend_m[i] & cfg_m[i].enable;
      valid_dut[i] = src_req_i[i].valid;
      // Claim and complete land only on an accepted request
      claim_hit[i] = claim_req_i && !claim_ack_i && above_m && (win_id == id_w'(i));
      done_hit[i]  = complete_req_i && !complete_ack_i && (complete_id_i == id_w'(i));
    end
  end

  ////////////////////////////////////////////////////////////
  // Model state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_m   <= '0;
      thr_m   <= '0;
      pend_m  <= '0;
      insvc_m <= '0;
      irq_m   <= 1'b0;
      rsp_m   <= '0;
    end else begin
      irq_m <= above_m;
      if (cfg_req_i && !cfg_ack_i) begin
        if (cfg_word_i.thresh.op == irq_cfg_pkg::OP_THRESH) begin
          thr_m <= cfg_word_i.thresh.threshold;
        end else begin
          cfg_m[cfg_word_i.src.src_id].enable <= cfg_word_i.src.enable;
          cfg_m[cfg_word_i.src.src_id].prio   <= cfg_word_i.src.prio;
        end
      end
      if (claim_req_i && !claim_ack_i) begin
        rsp_m.valid <= above_m;
        rsp_m.id    <= above_m ? win_id : '0;
      end
      for (int i = 0; i < num_src; i++) begin
        if (claim_hit[i] && pend_m[i]) begin
          pend_m[i]  <= 1'b0;
          insvc_m[i] <= 1'b1;
        end else if (done_hit[i] && insvc_m[i]) begin
          // Source level is ignored in the cycle service ends
          insvc_m[i] <= 1'b0;
        end else if (irq_src_i[i] && !pend_m[i] && !insvc_m[i]) begin
          pend_m[i] <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !cfg_ack_i && !claim_ack_i && !complete_ack_i && !irq_i &&
                     (claim_rsp_i == '0))
    else begin
      $error("Outputs not idle after reset");
      fail_count++;
    end

  // Every ack follows its req by exactly one cycle
  a_cfg_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_ack_i == $past(cfg_req_i))
    else begin
      $error("Configuration ack did not follow req by one cycle");
      fail_count++;
    end

  a_claim_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    claim_ack_i == $past(claim_req_i))
    else begin
      $error("Claim ack did not follow req by one cycle");
      fail_count++;
    end

  a_complete_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    complete_ack_i == $past(complete_req_i))
    else begin
      $error("Complete ack did not follow req by one cycle");
      fail_count++;
    end

  a_irq_line: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_i == irq_m)
    else begin
      $error("Interrupt line differs from the model");
      fail_count++;
    end

  a_claim_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    claim_rsp_i == rsp_m)
    else begin
      $error("Claim response differs from the model");
      fail_count++;
    end

  a_gateways: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_dut == valid_m)
    else begin
      $error("Gateway requests differ from the model");
      fail_count++;
    end

endmodule

bind irq_ctrl_top irq_ctrl_sva i_sva (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .irq_src_i      (irq_src_i),
  .cfg_req_i      (cfg_req_i),
  .cfg_word_i     (cfg_word_i),
  .cfg_ack_i      (cfg_ack_o),
  .claim_req_i    (claim_req_i),
  .claim_ack_i    (claim_ack_o),
  .claim_rsp_i    (claim_rsp_o),
  .complete_req_i (complete_req_i),
  .complete_id_i  (complete_id_i),
  .complete_ack_i (complete_ack_o),
  .irq_i          (irq_o),
  .src_req_i      (src_req)
);

/* test/irq_ctrl_tb.sv */
// Testbench for the single-target interrupt controller
// Runs configuration, claim and complete handshakes over fixed and
// random source patterns, while the bound checker compares the DUT

`timescale 1ns/10ps

`include "irq_settings.svh"

module irq_ctrl_tb;

  localparam int num_src    = `IRQ_NUM_SRC;
  localparam int id_w       = `IRQ_ID_W;
  localparam int num_rounds = 8;
  // Rough upper bound on handshakes and waits over all tests
  localparam int num_steps  = 80 + num_rounds * 27;
  localparam int hs_limit   = 20;
  localparam int irq_limit  = 10;

  logic                     clk_i;
  logic                     rst_i;
  logic [num_src-1:0]       irq_src_i;
  logic                     cfg_req_i;
  irq_cfg_pkg::cfg_word_u   cfg_word_i;
  logic                     cfg_ack_o;
  logic                     claim_req_i;
  logic                     claim_ack_o;
  irq_core_pkg::claim_rsp_t claim_rsp_o;
  logic                     complete_req_i;
  logic [id_w-1:0]          complete_id_i;
  logic                     complete_ack_o;
  logic                     irq_o;

  int                                     seed;
  int                                     rnd;
  int                                     timeout_errors;
  int                                     value_errors;
  logic [num_src-1:0]                     pattern;
  // What the testbench has configured so far
  logic [num_src-1:0]                     en_tb;
  logic [num_src-1:0][`IRQ_PRIO_W-1:0]    prio_tb;
  logic [`IRQ_PRIO_W-1:0]                 thr_tb;

  irq_ctrl_top i_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .irq_src_i      (irq_src_i),
    .cfg_req_i      (cfg_req_i),
    .cfg_word_i     (cfg_word_i),
    .cfg_ack_o      (cfg_ack_o),
    .claim_req_i    (claim_req_i),
    .claim_ack_o    (claim_ack_o),
    .claim_rsp_o    (claim_rsp_o),
    .complete_req_i (complete_req_i),
    .complete_id_i  (complete_id_i),
    .complete_ack_o (complete_ack_o),
    .irq_o          (irq_o)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Handshake tasks
  ////////////////////////////////////////////////////////////

  // Inputs change and outputs are read 2 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  // Port 0 is configuration, 1 is claim, 2 is complete
  function automatic logic ack_of(input int port);
    case (port)
      0: return cfg_ack_o;
      1: return claim_ack_o;
      default: return complete_ack_o;
    endcase
  endfunction

  task automatic set_req(input int port, input logic level);
    case (port)
      0: cfg_req_i = level;
      1: claim_req_i = level;
      default: complete_req_i = level;
    endcase
  endtask

  task automatic wait_ack(input int port, input logic level, input string name);
    int n;
    n = 0;
    step();
    while (ack_of(port) !== level && n < hs_limit) begin
      step();
      n++;
    end
    if (ack_of(port) !== level) begin
      timeout_errors++;
      $display("Error: %s ack did not go to %0d in time", name, level);
    end
  endtask

  // Runs one full four-phase cycle and holds req a random few cycles after ack
  task automatic run_handshake(input int port, input string name);
    int hold;
    rnd  = $random(seed);
    hold = int'(rnd[1:0]);
    set_req(port, 1'b1);
    wait_ack(port, 1'b1, name);
    repeat (hold) step();
    set_req(port, 1'b0);
    wait_ack(port, 1'b0, name);
  endtask

  task automatic cfg_src(input logic [id_w-1:0] id, input logic en,
                         input logic [`IRQ_PRIO_W-1:0] prio);
    irq_cfg_pkg::cfg_word_u w;
    w            = '0;
    w.src.op     = irq_cfg_pkg::OP_SRC;
    w.src.src_id = id;
    w.src.enable = en;
    w.src.prio   = prio;
    cfg_word_i   = w;
    en_tb[id]    = en;
    prio_tb[id]  = prio;
    run_handshake(0, "configuration");
  endtask

  task automatic cfg_thresh(input logic [`IRQ_PRIO_W-1:0] thr);
    irq_cfg_pkg::cfg_word_u w;
    w                  = '0;
    w.thresh.op        = irq_cfg_pkg::OP_THRESH;
    w.thresh.threshold = thr;
    cfg_word_i         = w;
    thr_tb             = thr;
    run_handshake(0, "configuration");
  endtask

  task automatic complete_src(input logic [id_w-1:0] id);
    complete_id_i = id;
    run_handshake(2, "complete");
  endtask

  // Enables every source with a random nonzero priority
  task automatic set_random_prios();
    for (int i = 0; i < num_src; i++) begin
      rnd = $random(seed);
      cfg_src(id_w'(i), 1'b1, (rnd[2:0] == 3'd0) ? 3'd1 : rnd[2:0]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Scans upward with a strict compare so the lowest index wins a tie
  function automatic irq_core_pkg::claim_rsp_t pick_winner(input logic [num_src-1:0] pend);
    irq_core_pkg::claim_rsp_t r;
    logic [`IRQ_PRIO_W-1:0]   best;
    r    = '0;
    best = '0;
    for (int i = 0; i < num_src; i++) begin
      if (pend[i] && en_tb[i] && prio_tb[i] > thr_tb && (!r.valid || prio_tb[i] > best)) begin
        r.valid = 1'b1;
        r.id    = id_w'(i);
        best    = prio_tb[i];
      end
    end
    return r;
  endfunction

  task automatic claim_check(input string name, input irq_core_pkg::claim_rsp_t exp);
    run_handshake(1, "claim");
    if (claim_rsp_o !== exp) begin
      value_errors++;
      $display("Fail %s expected valid %0d id %0d actual valid %0d id %0d",
               name, exp.valid, exp.id, claim_rsp_o.valid, claim_rsp_o.id);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Fail %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic wait_irq(input logic level, input string name);
    int n;
    n = 0;
    while (irq_o !== level && n < irq_limit) begin
      step();
      n++;
    end
    if (irq_o !== level) begin
      timeout_errors++;
      $display("Error: %s interrupt line never went to %0d", name, level);
    end
  endtask

  // Claims until nothing is left above the threshold, then completes all
  task automatic run_round(input string name, input logic [num_src-1:0] pend);
    irq_core_pkg::claim_rsp_t exp;
    logic [num_src-1:0]       claimed;
    claimed = '0;
    exp     = pick_winner(pend);
    while (exp.valid) begin
      claim_check(name, exp);
      pend[exp.id]    = 1'b0;
      claimed[exp.id] = 1'b1;
      exp             = pick_winner(pend);
    end
    claim_check(name, exp);
    for (int i = 0; i < num_src; i++) begin
      if (claimed[i]) begin
        complete_src(id_w'(i));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed           = 32'h9fcc_13e2;
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    irq_src_i      = '0;
    cfg_req_i      = 1'b0;
    cfg_word_i     = '0;
    claim_req_i    = 1'b0;
    complete_req_i = 1'b0;
    complete_id_i  = '0;
    en_tb          = '0;
    prio_tb        = '0;
    thr_tb         = '0;
    timeout_errors = 0;
    value_errors   = 0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    step();

    // All sources high with zero priority must never interrupt
    irq_src_i = '1;
    repeat (4) step();
    for (int i = 0; i < num_src; i++) begin
      cfg_src(id_w'(i), 1'b1, 3'd0);
    end
    repeat (4) step();
    check_bit("zero_prio", 1'b0, irq_o);
    claim_check("zero_prio", pick_winner('1));
    irq_src_i = '0;

    // Every gateway is still pending, so drain them all
    set_random_prios();
    run_round("drain", '1);

    // Threshold sweep on a single source at priority 5
    cfg_src(3'd3, 1'b1, 3'd5);
    irq_src_i[3] = 1'b1;
    wait_irq(1'b1, "thresh_0");
    cfg_thresh(3'd5);
    wait_irq(1'b0, "thresh_5");
    cfg_thresh(3'd4);
    wait_irq(1'b1, "thresh_4");

    // Claimed source stays blocked while its level is still high
    pattern    = '0;
    pattern[3] = 1'b1;
    claim_check("in_service", pick_winner(pattern));
    repeat (4) step();
    check_bit("in_service", 1'b0, irq_o);
    complete_src(3'd3);
    wait_irq(1'b1, "re_pend");
    claim_check("re_pend", pick_winner(pattern));
    irq_src_i = '0;
    complete_src(3'd3);

    // A complete aimed at a pending source that is not in service is ignored
    cfg_src(3'd6, 1'b1, 3'd7);
    irq_src_i[6] = 1'b1;
    step();
    irq_src_i = '0;
    complete_src(3'd6);
    pattern    = '0;
    pattern[6] = 1'b1;
    claim_check("stray_complete", pick_winner(pattern));
    complete_src(3'd6);

    // An empty claim returns nothing and leaves the gateways alone
    claim_check("idle_claim", pick_winner('0));
    cfg_thresh(3'd0);

    for (int r = 0; r < num_rounds; r++) begin
      set_random_prios();
      rnd       = $random(seed);
      pattern   = rnd[num_src-1:0];
      irq_src_i = pattern;
      repeat (2) step();
      irq_src_i = '0;
      run_round("random", pattern);
    end
    repeat (4) step();

    $display("Errors: %0d timeout, %0d value, %0d assertion",
             timeout_errors, value_errors, i_dut.i_sva.fail_count);
    if (timeout_errors == 0 && value_errors == 0 && i_dut.i_sva.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog that allows about 20 cycles per test step
  initial begin
    repeat (num_steps * 20) @(posedge clk_i);
    $display("Error: watchdog expired after %0d cycles", num_steps * 20);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
